/* bench/dram_fifo_assertions.sv */
/*
  concurrent protocol checks for the burst-buffered stream fifo
  bound into the top level
*/
`timescale 1ns/1ps
`default_nettype none

`include "dram_fifo_macros.svh"

module dram_fifo_assertions (
  input wire                         ddr3_axi_clk,
  input wire                         i_rst_n,
  input wire [`DF_DATA_W-1:0]        o_m_tdata,
  input wire                         o_m_tlast,
  input wire                         o_m_tvalid,
  input wire                         i_m_tready,
  input wire [`DF_LEVEL_W-1:0]       o_mem_level,
  input wire                         wr_req,
  input wire [`DF_LEN_W-1:0]         wr_len,
  input wire dram_fifo_pkg::mem_op_e mem_op
);
  import dram_fifo_pkg::*;

  logic [`DF_LEVEL_W-1:0] free_space;

  assign free_space = `DF_LEVEL_W'(`DF_DEPTH) - o_mem_level;  // level is static while idle

  // --------------------
  // output stream holds while stalled
  a_out_hold: assert property (@(posedge ddr3_axi_clk) disable iff (!i_rst_n)
    o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast))
    else $error("output word changed while stalled");

  a_level_max: assert property (@(posedge ddr3_axi_clk) disable iff (!i_rst_n)
    o_mem_level <= `DF_LEVEL_W'(`DF_DEPTH))
    else $error("memory level above depth");

  // --------------------
  // write grants only with room for the whole burst
  a_wr_space: assert property (@(posedge ddr3_axi_clk) disable iff (!i_rst_n)
    (mem_op == M_IDLE) && wr_req && (free_space < `DF_LEVEL_W'(wr_len)) |=> mem_op != M_WRITE)
    else $error("write burst granted without enough space");

endmodule

bind dram_fifo_top dram_fifo_assertions asrt_i (
  .ddr3_axi_clk (ddr3_axi_clk),
  .i_rst_n      (i_rst_n),
  .o_m_tdata    (o_m_tdata),
  .o_m_tlast    (o_m_tlast),
  .o_m_tvalid   (o_m_tvalid),
  .i_m_tready   (i_m_tready),
  .o_mem_level  (o_mem_level),
  .wr_req       (wr_req),
  .wr_len       (wr_len),
  .mem_op       (u_mem_ctrl.op)
);

`default_nettype wire

/* bench/dram_fifo_tb.sv */
/*
  testbench for the burst-buffered stream fifo
  clock, reset, stimulus, scoreboard checks, watchdog and reporting
*/
`timescale 1ns/1ps
`default_nettype none

`include "dram_fifo_macros.svh"

module dram_fifo_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int BACKP_WORDS  = `DF_DEPTH + 2 * `DF_BURST_LEN + 4;  // more than fits
  // cycle budget of each test and their sum for the watchdog
  localparam int CYC_RESET  = 40;
  localparam int CYC_ORDER  = 4000;
  localparam int CYC_FLUSH  = 400;
  localparam int CYC_BACKP  = 2500;
  localparam int CYC_RANDOM = 8000;
  localparam int CYC_TOTAL  = CYC_RESET + CYC_ORDER + CYC_FLUSH + 2 * CYC_BACKP + CYC_RANDOM;

  logic                   ddr3_axi_clk;
  logic                   i_rst_n;
  logic [`DF_DATA_W-1:0]  i_s_tdata;
  logic                   i_s_tlast;
  logic                   i_s_tvalid;
  logic                   o_s_tready;
  logic [`DF_DATA_W-1:0]  o_m_tdata;
  logic                   o_m_tlast;
  logic                   o_m_tvalid;
  logic                   i_m_tready;
  logic [`DF_LEVEL_W-1:0] o_mem_level;

  logic [`DF_WORD_W-1:0]  exp_q [$];   // accepted words with the last flag on top
  int                     error_cnt;
  int                     recv_cnt;
  int                     tests_passed;
  int                     tests_failed;
  int                     ready_mode;  // 0 open, 1 held low, 2 random
  integer                 seed;
  integer                 ready_seed;

  dram_fifo_top dut_i (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_s_tdata    (i_s_tdata),
    .i_s_tlast    (i_s_tlast),
    .i_s_tvalid   (i_s_tvalid),
    .o_s_tready   (o_s_tready),
    .o_m_tdata    (o_m_tdata),
    .o_m_tlast    (o_m_tlast),
    .o_m_tvalid   (o_m_tvalid),
    .i_m_tready   (i_m_tready),
    .o_mem_level  (o_mem_level)
  );

  always #(CLK_PERIOD / 2) ddr3_axi_clk = ~ddr3_axi_clk;

  // --------------------
  // output side drives tready and checks the word that the next rising edge takes
  always @(negedge ddr3_axi_clk) begin : out_side
    logic [`DF_WORD_W-1:0] want;
    logic [31:0]           rnd;
    rnd = $random(ready_seed);
    case (ready_mode)
      1:       i_m_tready = 1'b0;
      2:       i_m_tready = rnd[0];
      default: i_m_tready = 1'b1;
    endcase
    if (i_rst_n && o_m_tvalid && i_m_tready) begin  // transfer on the next rising edge
      if (exp_q.size() == 0) begin
        $display("output word at %0t arrived with nothing pending", $time);
        error_cnt++;
      end else begin
        want = exp_q.pop_front();
        assert ({o_m_tlast, o_m_tdata} == want) else begin
          $display("FAILED at %0t: word %0d got last=%0b data=%h, expected last=%0b data=%h",
                   $time, recv_cnt, o_m_tlast, o_m_tdata, want[`DF_DATA_W], want[`DF_DATA_W-1:0]);
          error_cnt++;
        end
        recv_cnt++;
      end
    end
  end

  // caller sits on a falling edge where tready is stable
  task automatic send_word(input logic [`DF_DATA_W-1:0] data, input logic last);
    i_s_tdata  = data;
    i_s_tlast  = last;
    i_s_tvalid = 1'b1;
    while (!o_s_tready) @(negedge ddr3_axi_clk);
    exp_q.push_back({last, data});  // taken on the next rising edge
    @(negedge ddr3_axi_clk);
  endtask

  task automatic send_packet(input int len, input bit gaps);
    logic [`DF_DATA_W-1:0] data;
    logic [31:0]           rnd;
    for (int i = 0; i < len; i++) begin
      data = {$random(seed), $random(seed)};
      send_word(data, i == len - 1);
      rnd = $random(seed);
      if (gaps && rnd[1:0] == 2'b00) begin  // idle beat now and then
        i_s_tvalid = 1'b0;
        @(negedge ddr3_axi_clk);
      end
    end
    i_s_tvalid = 1'b0;
  endtask

  task automatic set_ready(input int mode);
    @(posedge ddr3_axi_clk);
    ready_mode = mode;
    @(negedge ddr3_axi_clk);
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || o_m_tvalid) && cycles < limit) begin
      @(negedge ddr3_axi_clk);
      cycles++;
    end
    if (exp_q.size() != 0 || o_m_tvalid) begin
      $display("output did not drain within %0d cycles, %0d words pending", limit, exp_q.size());
      error_cnt++;
    end
    repeat (2) @(negedge ddr3_axi_clk);
  endtask

  task automatic close_test(input string name, input int err_before);
    if (error_cnt == err_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, error_cnt - err_before);
    end
  endtask

  // --------------------
  initial begin : main
    int          err_before;
    int          len;
    int          stall_run;
    bit          stalled;
    logic [31:0] rnd;
    seed         = 32'he8a9;
    ready_seed   = seed;
    ddr3_axi_clk = 1'b0;
    i_rst_n      = 1'b0;
    i_s_tdata    = '0;
    i_s_tlast    = 1'b0;
    i_s_tvalid   = 1'b0;
    i_m_tready   = 1'b1;
    ready_mode   = 0;
    error_cnt    = 0;
    recv_cnt     = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge ddr3_axi_clk);
    @(negedge ddr3_axi_clk);
    i_rst_n = 1'b1;
    @(negedge ddr3_axi_clk);

    err_before = error_cnt;
    assert (!o_m_tvalid && o_mem_level == '0 && o_s_tready) else begin
      $display("FAILED at %0t: after reset tvalid=%0b level=%0d tready=%0b",
               $time, o_m_tvalid, o_mem_level, o_s_tready);
      error_cnt++;
    end
    close_test("reset state", err_before);

    err_before = error_cnt;
    repeat (12) begin
      rnd = $random(seed);
      len = 1 + int'(rnd % 32'd20);   // 1 to 20 words
      send_packet(len, 1'b1);
    end
    wait_drain(CYC_ORDER);
    close_test("order and framing", err_before);

    err_before = error_cnt;
    send_packet(3, 1'b0);
    for (int i = 0; i < `DF_FLUSH_TIMEOUT; i++) begin
      assert (!o_m_tvalid) else begin
        $display("FAILED at %0t: output %0d cycles after the last word, before flush", $time, i);
        error_cnt++;
      end
      @(negedge ddr3_axi_clk);
    end
    wait_drain(CYC_FLUSH);
    close_test("partial burst flush", err_before);

    err_before = error_cnt;
    set_ready(1);
    stalled   = 1'b0;
    stall_run = 0;
    fork
      send_packet(BACKP_WORDS, 1'b0);
      begin
        for (int i = 0; i < CYC_BACKP && !stalled; i++) begin
          @(negedge ddr3_axi_clk);
          stall_run = o_s_tready ? 0 : stall_run + 1;
          stalled   = (stall_run >= 2 * `DF_FLUSH_TIMEOUT);  // writer parked for good
        end
        if (!stalled) begin
          $display("input never stalled while the output was held");
          error_cnt++;
        end
        assert (o_mem_level <= `DF_LEVEL_W'(`DF_DEPTH)) else begin
          $display("FAILED at %0t: level %0d above depth", $time, o_mem_level);
          error_cnt++;
        end
        set_ready(0);
      end
    join
    wait_drain(CYC_BACKP);
    close_test("back-pressure", err_before);

    err_before = error_cnt;
    set_ready(2);
    repeat (15) begin
      rnd = $random(seed);
      len = 1 + int'(rnd % 32'd20);
      send_packet(len, 1'b1);
    end
    wait_drain(CYC_RANDOM);
    assert (o_mem_level == '0 && !o_m_tvalid) else begin
      $display("FAILED at %0t: after drain level=%0d tvalid=%0b", $time, o_mem_level, o_m_tvalid);
      error_cnt++;
    end
    set_ready(0);
    close_test("random ready", err_before);

    $display("tests run %0d, passed %0d, failed %0d, words checked %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, recv_cnt, error_cnt);
    if (error_cnt == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + CYC_TOTAL) @(posedge ddr3_axi_clk);
    $display("timeout, the run did not finish within %0d cycles", RESET_CYCLES + CYC_TOTAL);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* common/dram_fifo_macros.svh */
/*
  sizing constants for the burst-buffered stream fifo
  widths, burst length, memory depth and flush timeout
*/
`ifndef DRAM_FIFO_MACROS_SVH
`define DRAM_FIFO_MACROS_SVH

// --------------------
// stream and stored word
`define DF_DATA_W        64   // stream payload width
`define DF_WORD_W        65   // payload plus last flag

// --------------------
// burst shape
`define DF_BURST_LEN     8    // max words per burst
`define DF_LEN_W         4    // holds 0..DF_BURST_LEN

// --------------------
// backing store
`define DF_DEPTH         64   // words, small so it fills quickly
`define DF_ADDR_W        6    // log2 of depth
`define DF_LEVEL_W       7    // holds 0..DF_DEPTH

`define DF_FLUSH_TIMEOUT 32   // idle cycles before a partial burst goes out

`endif

/* common/dram_fifo_pkg.sv */
/*
  shared types for the burst-buffered stream fifo
  stored word layout and the fsm state / opcode enums
*/
`default_nettype none

`include "dram_fifo_macros.svh"

package dram_fifo_pkg;

  // one stored word, last flag sits above the payload
  typedef struct packed {
    logic                  last;  // end of packet marker
    logic [`DF_DATA_W-1:0] data;  // stream payload
  } fifo_word_t;

  // burst writer fsm
  typedef enum logic [1:0] {
    W_FILL,   // collecting input words
    W_REQ,    // waiting for a write grant
    W_BURST   // replaying staged words
  } wr_state_e;

  // burst reader fsm
  typedef enum logic [1:0] {
    R_REQ,    // asking for a read burst
    R_FILL,   // storing incoming beats
    R_DRAIN   // presenting words on the output
  } rd_state_e;

  // memory controller operation
  typedef enum logic [1:0] {
    M_IDLE,   // arbitrating
    M_WRITE,  // write burst in flight
    M_READ    // read burst in flight
  } mem_op_e;

endpackage

`default_nettype wire

/* dram_fifo_top.f */
+incdir+common
common/dram_fifo_pkg.sv
hw/burst_mover/burst_writer.sv
hw/burst_mover/burst_reader.sv
hw/burst_mem_ctrl.sv
hw/dram_fifo_top.sv
bench/dram_fifo_assertions.sv
bench/dram_fifo_tb.sv

/* hw/burst_mem_ctrl.sv */
/*
  shared word memory with wrapping pointers and fill level
  grants one write or read burst at a time, alternating on contention
*/
`timescale 1ns/1ps
`default_nettype none

`include "dram_fifo_macros.svh"

module burst_mem_ctrl (
  input  wire                       ddr3_axi_clk,
  input  wire                       i_rst_n,
  input  wire                       i_wr_req,
  input  wire  [`DF_LEN_W-1:0]      i_wr_len,
  output logic                      o_wr_gnt,
  input  wire                       i_wr_valid,
  input  wire dram_fifo_pkg::fifo_word_t i_wr_word,
  input  wire                       i_wr_end,
  input  wire                       i_rd_req,
  output logic                      o_rd_valid,
  output dram_fifo_pkg::fifo_word_t o_rd_word,
  output logic                      o_rd_end,
  output logic [`DF_LEVEL_W-1:0]    o_mem_level
);
  import dram_fifo_pkg::*;

  mem_op_e               op;
  fifo_word_t            mem [`DF_DEPTH];  // backing store
  logic [`DF_ADDR_W-1:0] wr_ptr;
  logic [`DF_ADDR_W-1:0] rd_ptr;
  logic [`DF_LEVEL_W-1:0] level;           // words held
  logic [`DF_LEVEL_W-1:0] free_space;
  logic [`DF_LEN_W-1:0]  wr_len_q;         // granted write length
  logic [`DF_LEN_W-1:0]  rd_issue;         // reads left to issue
  logic [`DF_LEN_W-1:0]  rd_burst_len;
  logic                  last_rd;          // last grant went to the reader
  logic                  wr_ok;
  logic                  rd_ok;
  logic                  pick_rd;
  logic                  wr_fire;
  logic                  rd_fire;

  // --------------------
  // space, level and arbitration
  assign free_space   = `DF_LEVEL_W'(`DF_DEPTH) - level;
  assign wr_ok        = i_wr_req && (free_space >= `DF_LEVEL_W'(i_wr_len));
  assign rd_ok        = i_rd_req && (level != '0);
  assign pick_rd      = rd_ok && (!wr_ok || !last_rd);  // round robin on tie
  assign rd_burst_len = (level >= `DF_LEVEL_W'(`DF_BURST_LEN)) ?
                        `DF_LEN_W'(`DF_BURST_LEN) : level[`DF_LEN_W-1:0];

  assign wr_fire     = (op == M_WRITE) && i_wr_valid;   // every beat accepted
  assign rd_fire     = (op == M_READ) && (rd_issue != '0);
  assign o_mem_level = level;

  // memory array, registered read
  always_ff @(posedge ddr3_axi_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= i_wr_word;
    end
    if (rd_fire) begin
      o_rd_word <= mem[rd_ptr];
    end
  end

  // --------------------
  // operation fsm
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      op         <= M_IDLE;
      o_wr_gnt   <= 1'b0;
      o_rd_valid <= 1'b0;
      o_rd_end   <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      level      <= '0;
      wr_len_q   <= '0;
      rd_issue   <= '0;
      last_rd    <= 1'b0;
    end else begin
      o_wr_gnt   <= 1'b0;                           // grant is a single pulse
      o_rd_valid <= rd_fire;
      o_rd_end   <= rd_fire && (rd_issue == `DF_LEN_W'(1));
      if (rd_fire) begin
        rd_ptr   <= rd_ptr + 1'b1;                  // wraps at depth
        rd_issue <= rd_issue - 1'b1;
      end
      case (op)
        M_IDLE: begin
          if (pick_rd) begin
            op       <= M_READ;
            rd_issue <= rd_burst_len;
            level    <= level - `DF_LEVEL_W'(rd_burst_len);  // drop on grant
            last_rd  <= 1'b1;
          end else if (wr_ok) begin
            op       <= M_WRITE;
            o_wr_gnt <= 1'b1;
            wr_len_q <= i_wr_len;
            last_rd  <= 1'b0;
          end
        end
        M_WRITE: begin
          if (i_wr_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (i_wr_end) begin
              level <= level + `DF_LEVEL_W'(wr_len_q);  // burst now readable
              op    <= M_IDLE;
            end
          end
        end
        M_READ: begin
          if (o_rd_valid && o_rd_end) begin
            op <= M_IDLE;                           // final beat delivered
          end
        end
        default: op <= M_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/burst_mover/burst_reader.sv */
/*
  output side burst unpacker
  buffers one read burst, then drains it word by word to the stream
*/
`timescale 1ns/1ps
`default_nettype none

`include "dram_fifo_macros.svh"

module burst_reader (
  input  wire                       ddr3_axi_clk,
  input  wire                       i_rst_n,
  output logic                      o_rd_req,
  input  wire                       i_rd_valid,
  input  wire dram_fifo_pkg::fifo_word_t i_rd_word,
  input  wire                       i_rd_end,
  output logic [`DF_DATA_W-1:0]     o_m_tdata,
  output logic                      o_m_tlast,
  output logic                      o_m_tvalid,
  input  wire                       i_m_tready
);
  import dram_fifo_pkg::*;

  rd_state_e            state;
  fifo_word_t           rbuf [`DF_BURST_LEN];  // burst landing buffer
  fifo_word_t           head_word;             // word on the output
  logic [`DF_LEN_W-1:0] wr_idx;                // beats stored
  logic [`DF_LEN_W-1:0] rd_idx;                // words sent
  logic                 beat_in;
  logic                 m_xfer;
  logic                 last_out;

  assign beat_in  = i_rd_valid && (state != R_DRAIN);
  assign m_xfer   = o_m_tvalid && i_m_tready;
  assign last_out = (rd_idx == wr_idx - 1'b1);  // final buffered word

  // --------------------
  // stream side
  assign o_rd_req   = (state == R_REQ);         // only while buffer is empty
  assign head_word  = rbuf[rd_idx[`DF_LEN_W-2:0]];
  assign o_m_tvalid = (state == R_DRAIN);
  assign o_m_tdata  = head_word.data;
  assign o_m_tlast  = head_word.last;           // flag stays on its own word

  // buffer is not written while draining, so output holds under stall
  always_ff @(posedge ddr3_axi_clk) begin
    if (beat_in) begin
      rbuf[wr_idx[`DF_LEN_W-2:0]] <= i_rd_word;
    end
  end

  // --------------------
  // control fsm
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      state  <= R_REQ;
      wr_idx <= '0;
      rd_idx <= '0;
    end else begin
      case (state)
        R_REQ, R_FILL: begin
          if (i_rd_valid) begin
            wr_idx <= wr_idx + 1'b1;
            state  <= i_rd_end ? R_DRAIN : R_FILL;  // single beat skips fill
          end
        end
        R_DRAIN: begin
          if (m_xfer) begin
            rd_idx <= rd_idx + 1'b1;
            if (last_out) begin
              state  <= R_REQ;
              wr_idx <= '0;
              rd_idx <= '0;
            end
          end
        end
        default: state <= R_REQ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/burst_mover/burst_writer.sv */
/*
  input side burst packer
  stages stream words and flushes a partial burst after an idle timeout
*/
`timescale 1ns/1ps
`default_nettype none

`include "dram_fifo_macros.svh"

module burst_writer (
  input  wire                       ddr3_axi_clk,
  input  wire                       i_rst_n,
  input  wire  [`DF_DATA_W-1:0]     i_s_tdata,
  input  wire                       i_s_tlast,
  input  wire                       i_s_tvalid,
  output logic                      o_s_tready,
  output logic                      o_wr_req,
  output logic [`DF_LEN_W-1:0]      o_wr_len,
  input  wire                       i_wr_gnt,
  output logic                      o_wr_valid,
  output dram_fifo_pkg::fifo_word_t o_wr_word,
  output logic                      o_wr_end
);
  import dram_fifo_pkg::*;

  wr_state_e            state;
  fifo_word_t           stage_mem [`DF_BURST_LEN];  // staging buffer
  logic [`DF_LEN_W-1:0] fill_cnt;                   // words staged
  logic [`DF_LEN_W-1:0] beat_idx;                   // replay position
  logic [$clog2(`DF_FLUSH_TIMEOUT+1)-1:0] idle_cnt; // cycles since last accept
  logic                 s_accept;
  logic                 buf_full;
  logic                 flush_due;

  assign buf_full   = (fill_cnt == `DF_LEN_W'(`DF_BURST_LEN));
  assign flush_due  = (idle_cnt == `DF_FLUSH_TIMEOUT) && (fill_cnt != '0);
  assign o_s_tready = (state == W_FILL) && !buf_full;  // room left and not busy
  assign s_accept   = i_s_tvalid && o_s_tready;

  // --------------------
  // burst side outputs
  assign o_wr_req   = (state == W_REQ);
  assign o_wr_len   = fill_cnt;                         // stable while waiting
  assign o_wr_valid = (state == W_BURST);
  assign o_wr_word  = stage_mem[beat_idx[`DF_LEN_W-2:0]];
  assign o_wr_end   = o_wr_valid && (beat_idx == fill_cnt - 1'b1);

  // staging storage for payload and last flag
  always_ff @(posedge ddr3_axi_clk) begin
    if (s_accept) begin
      stage_mem[fill_cnt[`DF_LEN_W-2:0]] <= '{last: i_s_tlast, data: i_s_tdata};
    end
  end

  // --------------------
  // control fsm
  always_ff @(posedge ddr3_axi_clk) begin
    if (!i_rst_n) begin
      state    <= W_FILL;
      fill_cnt <= '0;
      beat_idx <= '0;
      idle_cnt <= '0;
    end else begin
      case (state)
        W_FILL: begin
          if (s_accept) begin
            fill_cnt <= fill_cnt + 1'b1;
            idle_cnt <= '0;                       // restart on every word
          end else if (fill_cnt != '0 && !flush_due) begin
            idle_cnt <= idle_cnt + 1'b1;          // saturates at timeout
          end
          if (buf_full || (flush_due && !s_accept)) begin
            state <= W_REQ;
          end
        end
        W_REQ: begin
          if (i_wr_gnt) begin
            state    <= W_BURST;
            beat_idx <= '0;
          end
        end
        W_BURST: begin
          beat_idx <= beat_idx + 1'b1;            // one beat per cycle without gaps
          if (o_wr_end) begin
            state    <= W_FILL;
            fill_cnt <= '0;
            idle_cnt <= '0;
          end
        end
        default: state <= W_FILL;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/dram_fifo_top.sv */
/*
  top level of the burst-buffered stream fifo
  burst writer, burst reader and the shared memory controller
*/
`timescale 1ns/1ps
`default_nettype none

`include "dram_fifo_macros.svh"

module dram_fifo_top (
  input  wire                   ddr3_axi_clk,
  input  wire                   i_rst_n,
  // input stream
  input  wire  [`DF_DATA_W-1:0] i_s_tdata,
  input  wire                   i_s_tlast,
  input  wire                   i_s_tvalid,
  output logic                  o_s_tready,
  // output stream
  output logic [`DF_DATA_W-1:0] o_m_tdata,
  output logic                  o_m_tlast,
  output logic                  o_m_tvalid,
  input  wire                   i_m_tready,
  // status
  output logic [`DF_LEVEL_W-1:0] o_mem_level
);
  import dram_fifo_pkg::*;

  // --------------------
  // writer to controller
  logic                 wr_req;
  logic [`DF_LEN_W-1:0] wr_len;
  logic                 wr_gnt;
  logic                 wr_valid;
  fifo_word_t           wr_word;
  logic                 wr_end;

  // --------------------
  // controller to reader
  logic                 rd_req;
  logic                 rd_valid;
  fifo_word_t           rd_word;
  logic                 rd_end;

  burst_writer u_writer (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_s_tdata    (i_s_tdata),
    .i_s_tlast    (i_s_tlast),
    .i_s_tvalid   (i_s_tvalid),
    .o_s_tready   (o_s_tready),
    .o_wr_req     (wr_req),
    .o_wr_len     (wr_len),
    .i_wr_gnt     (wr_gnt),
    .o_wr_valid   (wr_valid),
    .o_wr_word    (wr_word),
    .o_wr_end     (wr_end)
  );

  burst_mem_ctrl u_mem_ctrl (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .i_wr_req     (wr_req),
    .i_wr_len     (wr_len),
    .o_wr_gnt     (wr_gnt),
    .i_wr_valid   (wr_valid),
    .i_wr_word    (wr_word),
    .i_wr_end     (wr_end),
    .i_rd_req     (rd_req),
    .o_rd_valid   (rd_valid),
    .o_rd_word    (rd_word),
    .o_rd_end     (rd_end),
    .o_mem_level  (o_mem_level)
  );

  burst_reader u_reader (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst_n      (i_rst_n),
    .o_rd_req     (rd_req),
    .i_rd_valid   (rd_valid),
    .i_rd_word    (rd_word),
    .i_rd_end     (rd_end),
    .o_m_tdata    (o_m_tdata),
    .o_m_tlast    (o_m_tlast),
    .o_m_tvalid   (o_m_tvalid),
    .i_m_tready   (i_m_tready)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the stream fifo testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=dram_fifo_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module dram_fifo_tb \
  -f dram_fifo_top.f \
  --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
